/* src/dot8_pkg.sv */
// Shared sizes and types for the dot-product accelerator
// The add tree is built for exactly eight words per vector

package dot8_pkg;

   // ==============================
   // Sizes
   // ==============================
   localparam int WORD_W       = 16;
   localparam int VEC_LEN      = 8;
   localparam int NUM_VEC      = 8;
   localparam int OFFS_W       = $clog2(VEC_LEN);
   localparam int VIDX_W       = $clog2(NUM_VEC);
   // Address is the vector index followed by the word offset
   localparam int ADDR_W       = VIDX_W + OFFS_W;
   localparam int MEM_DEPTH    = NUM_VEC * VEC_LEN;
   localparam int NUM_LANES    = 2;
   localparam int LANE_IDX_W   = $clog2(NUM_LANES);
   // Input reg, products, first sums, final sum
   localparam int PIPE_LATENCY = 4;

   // ==============================
   // Types
   // ==============================
   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [ADDR_W-1:0]     addr_t;
   typedef logic [VIDX_W-1:0]     vec_idx_t;
   typedef logic [OFFS_W-1:0]     offs_t;
   typedef logic [NUM_LANES-1:0]  lane_mask_t;
   typedef logic [LANE_IDX_W-1:0] lane_idx_t;

   typedef enum logic [1:0] {
      fetch_idle,
      fetch_read,
      fetch_issue
   } fetch_state_t;

endpackage

/* src/operand_ram.sv */
// Single write port, single registered read port, read data one cycle late
// Read and write to the same address in one cycle returns the old word

`timescale 1ns/100ps

module operand_ram
   import dot8_pkg::*;
(
   input  logic  clk,
   // Host write side
   input  logic  wr_en,
   input  addr_t wr_addr,
   input  word_t wr_data,
   // Arbitrated read side
   input  addr_t rd_addr,
   output word_t rd_data
);

   // Eight vectors of eight words, vector index in the upper address bits
   word_t mem [MEM_DEPTH];

   // Host writes land at the edge where wr_en is high
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Read every cycle
   // lanes only capture the word when they held the grant
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* src/ram_arbiter.sv */
// Round-robin grant of the memory read port, decided in the request cycle
// Grant is zero only when no lane requests

`timescale 1ns/100ps

module ram_arbiter
   import dot8_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  lane_mask_t req,
   input  addr_t      lane_addr [NUM_LANES],
   output lane_mask_t grant,
   output addr_t      rd_addr
);

   lane_idx_t last_r;
   lane_idx_t win;
   lane_idx_t cand;
   logic      found;

   // ==============================
   // Grant selection
   // ==============================
   // Search starts at the lane after the last winner
   always_comb begin
      grant = '0;
      win   = last_r;
      found = 1'b0;
      for (int i = 1; i <= NUM_LANES; i++) begin
         cand = lane_idx_t'((int'(last_r) + i) % NUM_LANES);
         if (!found && req[cand]) begin
            found = 1'b1;
            win   = cand;
         end
      end
      if (found) begin
         grant[win] = 1'b1;
      end
   end

   // Winner's address goes to the memory
   // with no grant the address is a don't care
   assign rd_addr = lane_addr[win];

   // ==============================
   // Last granted lane
   // ==============================
   // Reset to the top lane so lane 0 wins the first tie
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         last_r <= lane_idx_t'(NUM_LANES - 1);
      end else if (found) begin
         last_r <= win;
      end
   end

endmodule

/* src/vector_fetch.sv */
// Reads eight words of one vector, then strobes the whole vector for one cycle
// A start that arrives while busy is dropped

`timescale 1ns/100ps

module vector_fetch
   import dot8_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   // Host control
   input  logic     start,
   input  vec_idx_t vec_idx,
   // Memory read port
   input  logic     grant,
   input  word_t    rd_data,
   output logic     rd_req,
   output addr_t    rd_addr,
   // Status and pipeline side
   output logic     busy,
   output word_t    vec_data [VEC_LEN],
   output logic     vec_valid
);

   fetch_state_t state_r;
   vec_idx_t     idx_r;
   offs_t        req_offs_r;
   offs_t        cap_offs_r;
   logic         granted_r;
   logic         vec_valid_r;

   // Request held until granted, address only moves on a grant
   assign rd_req    = (state_r == fetch_read);
   assign rd_addr   = {idx_r, req_offs_r};
   assign busy      = (state_r != fetch_idle);
   assign vec_valid = vec_valid_r;

   // ==============================
   // Sequencer
   // ==============================
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_r     <= fetch_idle;
         idx_r       <= '0;
         req_offs_r  <= '0;
         cap_offs_r  <= '0;
         granted_r   <= 1'b0;
         vec_valid_r <= 1'b0;
      end else begin
         // Word for a grant comes back one cycle later
         granted_r   <= rd_req && grant;
         vec_valid_r <= 1'b0;

         case (state_r)
            fetch_idle: begin
               if (start) begin
                  idx_r      <= vec_idx;
                  req_offs_r <= '0;
                  cap_offs_r <= '0;
                  state_r    <= fetch_read;
               end
            end
            fetch_read: begin
               if (grant) begin
                  req_offs_r <= req_offs_r + 1'b1;
                  if (req_offs_r == offs_t'(VEC_LEN - 1)) begin
                     state_r <= fetch_issue;
                  end
               end
            end
            fetch_issue: begin
               // Last word is captured on this edge
               if (granted_r) begin
                  vec_valid_r <= 1'b1;
                  state_r     <= fetch_idle;
               end
            end
            default: state_r <= fetch_idle;
         endcase

         if (granted_r) begin
            cap_offs_r <= cap_offs_r + 1'b1;
         end
      end
   end

   // Vector register, filled in word order
   always_ff @(posedge clk) begin
      if (granted_r) begin
         vec_data[cap_offs_r] <= rd_data;
      end
   end

endmodule

/* src/dot8_pipeline.sv */
// Unsigned multiply and add tree, fixed at eight inputs, all stages wrap mod 2^16
// No stall, a new vector may enter every cycle

`timescale 1ns/100ps

module dot8_pipeline
   import dot8_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  word_t vec_data [VEC_LEN],
   input  logic  vec_valid,
   output word_t result,
   output logic  result_valid
);

   word_t in_r   [VEC_LEN];
   word_t prod_r [VEC_LEN/2];
   word_t sum_r  [VEC_LEN/4];
   word_t result_r;

   // One bit per stage, oldest at the top
   logic [PIPE_LATENCY-1:0] valid_sr;

   // ==============================
   // Datapath
   // ==============================
   always_ff @(posedge clk) begin
      // Stage 1, capture the vector
      in_r <= vec_data;

      // Stage 2, pairwise products, upper half dropped
      for (int i = 0; i < VEC_LEN/2; i++) begin
         prod_r[i] <= in_r[2*i] * in_r[2*i+1];
      end

      // Stage 3, first tree level
      for (int i = 0; i < VEC_LEN/4; i++) begin
         sum_r[i] <= prod_r[2*i] + prod_r[2*i+1];
      end

      // Stage 4, final sum, carry out dropped
      result_r <= sum_r[0] + sum_r[1];
   end

   assign result = result_r;

   // ==============================
   // Valid delay line
   // ==============================
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_sr <= '0;
      end else begin
         valid_sr <= {valid_sr[PIPE_LATENCY-2:0], vec_valid};
      end
   end

   assign result_valid = valid_sr[PIPE_LATENCY-1];

endmodule

/* src/dot8_top.sv */
// Two compute lanes sharing one operand memory through a round-robin arbiter
// Each lane gives its result as a one-cycle strobe, nothing is queued

`timescale 1ns/100ps

module dot8_top
   import dot8_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   // Host memory load
   input  logic       wr_en,
   input  addr_t      wr_addr,
   input  word_t      wr_data,
   // Lane control
   input  lane_mask_t start,
   input  vec_idx_t   lane0_vec_idx,
   input  vec_idx_t   lane1_vec_idx,
   output lane_mask_t busy,
   // Results
   output word_t      lane0_result,
   output word_t      lane1_result,
   output lane_mask_t result_valid
);

   // Per-lane wiring, indexed by lane
   vec_idx_t   lane_idx    [NUM_LANES];
   addr_t      lane_addr   [NUM_LANES];
   word_t      lane_vec    [NUM_LANES][VEC_LEN];
   word_t      lane_result [NUM_LANES];
   lane_mask_t rd_req;
   lane_mask_t grant;
   lane_mask_t vec_valid;
   addr_t      rd_addr;
   word_t      rd_data;

   assign lane_idx[0]  = lane0_vec_idx;
   assign lane_idx[1]  = lane1_vec_idx;
   assign lane0_result = lane_result[0];
   assign lane1_result = lane_result[1];

   // ==============================
   // Shared memory and arbiter
   // ==============================
   operand_ram i_ram (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   ram_arbiter i_arb (
      .clk       (clk),
      .rst       (rst),
      .req       (rd_req),
      .lane_addr (lane_addr),
      .grant     (grant),
      .rd_addr   (rd_addr)
   );

   // ==============================
   // Lanes
   // ==============================
   for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
      // Read data is broadcast, each lane keeps only its own words
      vector_fetch i_fetch (
         .clk       (clk),
         .rst       (rst),
         .start     (start[l]),
         .vec_idx   (lane_idx[l]),
         .grant     (grant[l]),
         .rd_data   (rd_data),
         .rd_req    (rd_req[l]),
         .rd_addr   (lane_addr[l]),
         .busy      (busy[l]),
         .vec_data  (lane_vec[l]),
         .vec_valid (vec_valid[l])
      );

      dot8_pipeline i_pipe (
         .clk          (clk),
         .rst          (rst),
         .vec_data     (lane_vec[l]),
         .vec_valid    (vec_valid[l]),
         .result       (lane_result[l]),
         .result_valid (result_valid[l])
      );
   end

endmodule

/* bench/dot8_assertions.sv */
// Arbiter and pipeline protocol checks, bound into the top level
// Delay check only starts once PIPE_LATENCY cycles have passed after reset

`timescale 1ns/100ps

module dot8_assertions
   import dot8_pkg::*;
(
   input logic       clk,
   input logic       rst,
   input lane_mask_t rd_req,
   input lane_mask_t grant,
   input lane_mask_t vec_valid,
   input lane_mask_t result_valid
);

   int unsigned since_rst;

   // Cycles since reset, saturating at the pipeline depth
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         since_rst <= 0;
      end else if (since_rst < PIPE_LATENCY) begin
         since_rst <= since_rst + 1;
      end
   end

   // ==============================
   // Arbiter
   // ==============================
   grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
      else $error("grant is neither zero nor one-hot: %b", grant);

   // Only a requesting lane may hold the read port
   grant_to_req: assert property (@(posedge clk) disable iff (rst) (grant & ~rd_req) == '0)
      else $error("grant %b without request %b", grant, rd_req);

   // ==============================
   // Pipelines
   // ==============================
   valid_delay: assert property (@(posedge clk) disable iff (rst)
      since_rst >= PIPE_LATENCY |-> result_valid == $past(vec_valid, PIPE_LATENCY))
      else $error("result_valid %b does not follow vec_valid", result_valid);

   // Nothing can leave the pipeline before it has filled
   quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
      since_rst < PIPE_LATENCY |-> result_valid == '0)
      else $error("result_valid %b too soon after reset", result_valid);

endmodule

bind dot8_top dot8_assertions i_assert (
   .clk          (clk),
   .rst          (rst),
   .rd_req       (rd_req),
   .grant        (grant),
   .vec_valid    (vec_valid),
   .result_valid (result_valid)
);

/* bench/dot8_tb.sv */
// Directed and random tests of the two-lane dot-product accelerator
// Expected results come from a host copy of the operand memory, all math mod 2^16

`timescale 1ns/100ps

module dot8_tb
   import dot8_pkg::*;
();

   localparam int RAND_STARTS    = 16;
   // Vectors started over all tests, the ignored start included
   localparam int TOTAL_VECS     = 9 + RAND_STARTS;
   localparam int TIMEOUT_CYCLES = 2 * 40 * TOTAL_VECS;

   logic       clk = 1'b0;
   logic       rst;
   logic       wr_en;
   addr_t      wr_addr;
   word_t      wr_data;
   lane_mask_t start;
   vec_idx_t   lane0_vec_idx;
   vec_idx_t   lane1_vec_idx;
   lane_mask_t busy;
   word_t      lane0_result;
   word_t      lane1_result;
   lane_mask_t result_valid;

   // Host-side model state
   word_t       mem_model [MEM_DEPTH];
   word_t       vec_buf   [VEC_LEN];
   word_t       exp_q0 [$];
   word_t       exp_q1 [$];
   logic [15:0] lfsr_r = 16'd95;
   int          err_count = 0;
   int          pass_count = 0;
   int          cycles = 0;

   dot8_top i_dut (.*);

   always #5 clk = ~clk;

   // ==============================
   // Model and checks
   // ==============================
   // Taps 16 14 13 11, maximal length
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken
   task automatic take_bits(input int n, output word_t val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         val    = {val[WORD_W-2:0], lfsr_r[15]};
         lfsr_r = lfsr_next(lfsr_r);
      end
   endtask

   // Pairs 0*1, 2*3, 4*5, 6*7 summed, carries dropped
   function automatic word_t dot_model(input vec_idx_t v);
      word_t               acc;
      logic [2*WORD_W-1:0] prod;
      acc = '0;
      for (int i = 0; i < VEC_LEN; i += 2) begin
         prod = mem_model[int'(v)*VEC_LEN + i] * mem_model[int'(v)*VEC_LEN + i + 1];
         acc  = acc + prod[WORD_W-1:0];
      end
      return acc;
   endfunction

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         err_count++;
         $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      end else begin
         pass_count++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         err_count++;
         $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
      end else begin
         pass_count++;
      end
   endtask

   // ==============================
   // Result monitor
   // ==============================
   // Each lane pops its own queue, results must come back in start order
   task automatic take_result(input int lane, input word_t act);
      word_t exp;
      if ((lane == 0 && exp_q0.size() == 0) || (lane == 1 && exp_q1.size() == 0)) begin
         err_count++;
         $display("lane %0d gave a result at %0t with no vector outstanding", lane, $time);
      end else if (lane == 0) begin
         exp = exp_q0.pop_front();
         check_word("lane0_result", exp, act);
      end else begin
         exp = exp_q1.pop_front();
         check_word("lane1_result", exp, act);
      end
   endtask

   always @(negedge clk) begin
      if (!rst && result_valid[0]) take_result(0, lane0_result);
      if (!rst && result_valid[1]) take_result(1, lane1_result);
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, results still missing", cycles);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   // ==============================
   // Stimulus, entered and left at a falling edge
   // ==============================
   task automatic load_vector(input vec_idx_t v);
      for (int i = 0; i < VEC_LEN; i++) begin
         wr_en   = 1'b1;
         wr_addr = {v, offs_t'(i)};
         wr_data = vec_buf[i];
         mem_model[int'(v)*VEC_LEN + i] = vec_buf[i];
         @(negedge clk);
      end
      wr_en = 1'b0;
   endtask

   // Expected value is queued only when the start should be taken
   task automatic start_lane(input int lane, input vec_idx_t v, input word_t exp,
                             input bit taken);
      if (lane == 0) lane0_vec_idx = v;
      else lane1_vec_idx = v;
      if (taken && lane == 0) exp_q0.push_back(exp);
      if (taken && lane == 1) exp_q1.push_back(exp);
      start[lane] = 1'b1;
      @(negedge clk);
      start = '0;
   endtask

   task automatic wait_idle(input int lane);
      while (busy[lane]) @(negedge clk);
   endtask

   // Extra cycles catch a stray second result
   task automatic wait_drain();
      while (exp_q0.size() != 0 || exp_q1.size() != 0) @(negedge clk);
      repeat (PIPE_LATENCY + 2) @(negedge clk);
   endtask

   task automatic report_test(input string name, input int errs_before);
      $display("test %s finished with %0d errors", name, err_count - errs_before);
   endtask

   // ==============================
   // Tests
   // ==============================
   task automatic test_single();
      int errs;
      errs = err_count;
      check_flag("busy[0]", 1'b0, busy[0]);
      check_flag("busy[1]", 1'b0, busy[1]);
      check_flag("result_valid[0]", 1'b0, result_valid[0]);
      check_flag("result_valid[1]", 1'b0, result_valid[1]);
      vec_buf = '{16'd1, 16'd2, 16'd3, 16'd4, 16'd5, 16'd6, 16'd7, 16'd8};
      load_vector(0);
      // 2 + 12 + 30 + 56
      start_lane(0, 0, 16'd100, 1'b1);
      wait_drain();
      report_test("single", errs);
   endtask

   task automatic test_wrap();
      int errs;
      errs = err_count;
      vec_buf = '{16'hFFFF, 16'hFFFF, 16'hFFFE, 16'hFFFD,
                  16'h8000, 16'h8001, 16'hF00F, 16'hFF10};
      load_vector(1);
      start_lane(0, 1, dot_model(1), 1'b1);
      wait_drain();
      report_test("wrap", errs);
   endtask

   task automatic test_contention();
      int errs;
      errs = err_count;
      vec_buf = '{16'd10, 16'd20, 16'd30, 16'd40, 16'd50, 16'd60, 16'd70, 16'd80};
      load_vector(2);
      vec_buf = '{16'h1234, 16'h0003, 16'h00FF, 16'h0101, 16'h7FFF, 16'h0002,
                  16'h0400, 16'h0040};
      load_vector(3);
      lane0_vec_idx = 2;
      lane1_vec_idx = 3;
      exp_q0.push_back(dot_model(2));
      exp_q1.push_back(dot_model(3));
      start = 2'b11;
      @(negedge clk);
      start = '0;
      wait_drain();
      check_flag("busy[0]", 1'b0, busy[0]);
      check_flag("busy[1]", 1'b0, busy[1]);
      report_test("contention", errs);
   endtask

   task automatic test_overlap();
      int errs;
      errs = err_count;
      for (int i = 1; i <= 3; i++) begin
         wait_idle(0);
         start_lane(0, vec_idx_t'(i), dot_model(vec_idx_t'(i)), 1'b1);
      end
      wait_drain();
      report_test("overlap", errs);
   endtask

   task automatic test_busy_start();
      int errs;
      errs = err_count;
      start_lane(1, 0, dot_model(0), 1'b1);
      check_flag("busy[1]", 1'b1, busy[1]);
      // Lane is busy, this one must be dropped
      start_lane(1, 2, '0, 1'b0);
      wait_drain();
      report_test("busy_start", errs);
   endtask

   task automatic test_random();
      int    errs;
      int    issued;
      word_t w;
      errs   = err_count;
      issued = 0;
      for (int v = 0; v < NUM_VEC; v++) begin
         for (int i = 0; i < VEC_LEN; i++) begin
            take_bits(WORD_W, w);
            vec_buf[i] = w;
         end
         load_vector(vec_idx_t'(v));
      end
      // Start any idle lane on a random vector
      while (issued < RAND_STARTS) begin
         for (int l = 0; l < NUM_LANES; l++) begin
            if (!busy[l] && issued < RAND_STARTS) begin
               take_bits(VIDX_W, w);
               if (l == 0) lane0_vec_idx = vec_idx_t'(w);
               else lane1_vec_idx = vec_idx_t'(w);
               if (l == 0) exp_q0.push_back(dot_model(vec_idx_t'(w)));
               else exp_q1.push_back(dot_model(vec_idx_t'(w)));
               start[l] = 1'b1;
               issued++;
            end
         end
         @(negedge clk);
         start = '0;
      end
      wait_drain();
      report_test("random", errs);
   endtask

   initial begin
      rst           = 1'b1;
      wr_en         = 1'b0;
      wr_addr       = '0;
      wr_data       = '0;
      start         = '0;
      lane0_vec_idx = '0;
      lane1_vec_idx = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      test_single();
      test_wrap();
      test_contention();
      test_overlap();
      test_busy_start();
      test_random();
      $display("checks passed %0d, failed %0d", pass_count, err_count);
      if (err_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* dot8.f */
src/dot8_pkg.sv
src/operand_ram.sv
src/ram_arbiter.sv
src/vector_fetch.sv
src/dot8_pipeline.sv
src/dot8_top.sv
bench/dot8_assertions.sv
bench/dot8_tb.sv

/* Makefile */
# Verilator build and run of the dot-product accelerator testbench

VERILATOR ?= verilator
TOP       ?= dot8_tb
RTL_TOP   ?= dot8_top
FILELIST  ?= dot8.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "SIMULATION FAILED" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) src/dot8_pkg.sv src/operand_ram.sv \
		src/ram_arbiter.sv src/vector_fetch.sv src/dot8_pipeline.sv src/dot8_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)
